// ==== pvp_cfg.svh ====
/*
 * pvp configuration: datapath widths and integer ALU latency
 */
`ifndef PVP_CFG_SVH
`define PVP_CFG_SVH

// ==========================================================
// datapath widths
// ==========================================================

// one data word
`define PVP_DATA_W 32

// register number, 128 registers
`define PVP_REG_AW 7

// program memory address, 128 instruction words
`define PVP_PROG_AW 7

// ==========================================================
// pipeline
// ==========================================================

// cycles from alu request to write-back record
`define PVP_ALU_LAT 2

`endif

// ==== pvp_pkg.sv ====
/*
 * pvp types: data vectors, opcodes, sequencer states and the
 * packed records handed between the pipeline stages
 */
`include "pvp_cfg.svh"

package pvp_pkg;

	// plain vectors with a meaning
	typedef logic [`PVP_DATA_W-1:0]  data_t;
	typedef logic [`PVP_REG_AW-1:0]  reg_addr_t;
	typedef logic [`PVP_PROG_AW-1:0] prog_addr_t;
	// contents of r2, bit 0 steers the select instruction
	typedef logic [1:0]              flags_t;

	// ==========================================================
	// encodings
	// ==========================================================

	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_MUL   = 4'd3,
		OP_AND   = 4'd4,
		OP_OR    = 4'd5,
		OP_XOR   = 4'd6,
		OP_CMPLT = 4'd7,
		OP_SEL   = 4'd8,
		OP_HALT  = 4'd9
	} opcode_e;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN
	} seq_state_e;

	// ==========================================================
	// stage records
	// ==========================================================

	// program memory word, 25 bits
	typedef struct packed {
		opcode_e   op;
		reg_addr_t a_addr;
		reg_addr_t b_addr;
		reg_addr_t w_addr;
	} instr_t;

	// sequencer to register file
	typedef struct packed {
		logic      valid;
		opcode_e   op;
		reg_addr_t w_addr;
	} issue_t;

	// register file to alu, operands already resolved
	typedef struct packed {
		logic      valid;
		opcode_e   op;
		reg_addr_t w_addr;
		data_t     a;
		data_t     b;
		flags_t    flags;
	} alu_req_t;

	// alu back to register file and sequencer
	typedef struct packed {
		logic      w_en;
		logic      halt;
		reg_addr_t w_addr;
		data_t     r;
	} wb_t;

endpackage

// ==== pvp_seq.sv ====
/*
 * pvp sequencer: program memory, program counter and run control,
 * one instruction issued per cycle from start until halt or wrap
 */
`include "pvp_cfg.svh"

module pvp_seq (
	input  logic                sys_clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                prog_we,
	input  pvp_pkg::prog_addr_t prog_addr,
	input  pvp_pkg::instr_t     prog_data,
	input  pvp_pkg::wb_t        wb,
	output pvp_pkg::reg_addr_t  a_addr,
	output pvp_pkg::reg_addr_t  b_addr,
	output pvp_pkg::issue_t     issue,
	output logic                busy,
	output logic                done
);
	import pvp_pkg::*;

	instr_t     prog_mem [0:(1 << `PVP_PROG_AW)-1];
	seq_state_e state;
	prog_addr_t pc;
	// fetched word, valid one cycle after its pc was presented
	instr_t     ir;
	logic       ir_valid;
	// pc has wrapped past the last address during this run
	logic       end_q;
	// replaces the word after a wrap with a halt
	logic       force_halt;
	opcode_e    ir_op;
	logic       halt_seen;
	logic       fetch_en;

	// ==========================================================
	// program memory
	// ==========================================================

	// host write only while idle, synchronous read by pc
	always_ff @(posedge sys_clk) begin
		if (prog_we && !busy) begin
			prog_mem[prog_addr] <= prog_data;
		end
		ir <= prog_mem[pc];
	end

	// ==========================================================
	// fetch and run control
	// ==========================================================

	assign ir_op     = force_halt ? OP_HALT : ir.op;
	// a halt in the fetch stage stops any further issue
	assign halt_seen = ir_valid && (ir_op == OP_HALT);
	assign fetch_en  = (state == SEQ_RUN) && !halt_seen;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state      <= SEQ_IDLE;
			pc         <= '0;
			ir_valid   <= 1'b0;
			end_q      <= 1'b0;
			force_halt <= 1'b0;
		end else begin
			ir_valid   <= fetch_en;
			// the slot after the wrapped word carries a halt
			force_halt <= end_q && fetch_en;
			case (state)
				SEQ_IDLE: begin
					if (start) begin
						state <= SEQ_RUN;
						pc    <= '0;
						end_q <= 1'b0;
					end
				end
				SEQ_RUN: begin
					if (halt_seen) begin
						state <= SEQ_DRAIN;
					end else begin
						pc <= pc + 1'b1;
						if (pc == '1) begin
							end_q <= 1'b1;
						end
					end
				end
				SEQ_DRAIN: begin
					// the halt leaves the alu after the last write
					if (wb.halt) begin
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// read addresses go out in the same cycle as the issue record
	assign a_addr = ir.a_addr;
	assign b_addr = ir.b_addr;
	assign issue  = '{valid: ir_valid, op: ir_op, w_addr: ir.w_addr};

	assign busy = (state != SEQ_IDLE);
	assign done = wb.halt && (state == SEQ_DRAIN);

endmodule

// ==== pvp_regf.sv ====
/*
 * pvp register file: two read ports and one write port, with r0, r1
 * and the flags register r2 overlaid, plus host access and write traps
 */
`include "pvp_cfg.svh"

module pvp_regf (
	input  logic               sys_clk,
	input  logic               rst_n,
	input  pvp_pkg::reg_addr_t a_addr,
	input  pvp_pkg::reg_addr_t b_addr,
	input  pvp_pkg::issue_t    issue,
	input  pvp_pkg::wb_t       wb,
	input  logic               c_en,
	input  logic               c_w_en,
	input  pvp_pkg::reg_addr_t c_addr,
	input  pvp_pkg::data_t     c_di,
	input  logic               start,
	input  pvp_pkg::data_t     r0_in,
	input  pvp_pkg::data_t     r1_in,
	output pvp_pkg::alu_req_t  alu_req,
	output pvp_pkg::data_t     c_do,
	output logic               out_en,
	output pvp_pkg::data_t     out_d,
	output logic               err_stray
);
	import pvp_pkg::*;

	localparam reg_addr_t R_ZERO  = reg_addr_t'(0);
	localparam reg_addr_t R_ONE   = reg_addr_t'(1);
	localparam reg_addr_t R_FLAGS = reg_addr_t'(2);
	// output register, streamed out on every write
	localparam reg_addr_t R_OUT   = '1;

	data_t     ram [0:(1 << `PVP_REG_AW)-1];
	reg_addr_t p1_a;
	reg_addr_t p2_a;
	logic      p3_en;
	reg_addr_t p3_a;
	data_t     p3_d;
	data_t     p1_q;
	data_t     p2_q;
	logic      p1_ovl_en;
	logic      p2_ovl_en;
	data_t     p1_ovl;
	data_t     p2_ovl;
	data_t     a_val;
	data_t     b_val;
	data_t     r0_q;
	data_t     r1_q;
	flags_t    rflags;
	flags_t    flags_q;
	issue_t    issue_q;

	// value seen through the overlay for r0, r1 and r2
	function automatic data_t overlay_val(input reg_addr_t addr);
		data_t v;
		case (addr)
			R_ZERO:  v = r0_q;
			R_ONE:   v = r1_q;
			default: v = data_t'(rflags);
		endcase
		return v;
	endfunction

	// ==========================================================
	// port muxing, host takes priority
	// ==========================================================

	// port 1 is shared with host reads
	assign p1_a  = c_en ? c_addr : a_addr;
	// port 2 belongs to the alu alone
	assign p2_a  = b_addr;
	// write port is shared with host writes
	assign p3_en = c_en ? c_w_en : wb.w_en;
	assign p3_a  = c_en ? c_addr : wb.w_addr;
	assign p3_d  = c_en ? c_di : wb.r;

	// ==========================================================
	// storage
	// ==========================================================

	// read returns old data when read and write hit the same edge
	always_ff @(posedge sys_clk) begin
		if (p3_en) begin
			ram[p3_a] <= p3_d;
		end
		p1_q <= ram[p1_a];
		p2_q <= ram[p2_a];
	end

	// overlay selects registered alongside the ram read
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			p1_ovl_en <= 1'b0;
			p2_ovl_en <= 1'b0;
		end else begin
			p1_ovl_en <= (p1_a <= R_FLAGS);
			p2_ovl_en <= (p2_a <= R_FLAGS);
		end
		p1_ovl <= overlay_val(p1_a);
		p2_ovl <= overlay_val(p2_a);
	end

	assign a_val = p1_ovl_en ? p1_ovl : p1_q;
	assign b_val = p2_ovl_en ? p2_ovl : p2_q;
	// host read data is valid one cycle after the request
	assign c_do  = a_val;

	// input coordinates, held for the whole run
	always_ff @(posedge sys_clk) begin
		if (start) begin
			r0_q <= r0_in;
			r1_q <= r1_in;
		end
	end

	// ==========================================================
	// flags and issue alignment
	// ==========================================================

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			rflags  <= '0;
			flags_q <= '0;
			issue_q <= '0;
		end else begin
			// catch writes to r2
			if (p3_en && (p3_a == R_FLAGS)) begin
				rflags <= p3_d[1:0];
			end
			// one cycle behind, matches the operand read
			flags_q <= rflags;
			issue_q <= issue;
		end
	end

	assign alu_req = '{
		valid:  issue_q.valid,
		op:     issue_q.op,
		w_addr: issue_q.w_addr,
		a:      a_val,
		b:      b_val,
		flags:  flags_q
	};

	// ==========================================================
	// write traps
	// ==========================================================

	// r0 is read-only, any write is flagged
	assign err_stray = p3_en && (p3_a == R_ZERO);
	assign out_en    = p3_en && (p3_a == R_OUT);
	assign out_d     = p3_d;

endmodule

// ==== pvp_alu.sv ====
/*
 * pvp integer alu: opcode selects the result in stage one, later
 * stages carry the write-back record to the register file
 */
`include "pvp_cfg.svh"

module pvp_alu (
	input  logic              sys_clk,
	input  logic              rst_n,
	input  pvp_pkg::alu_req_t req,
	output pvp_pkg::wb_t      wb
);
	import pvp_pkg::*;

	// total stages from request to write-back record
	localparam int LAT = `PVP_ALU_LAT;

	data_t     res;
	logic      s1_valid;
	opcode_e   s1_op;
	reg_addr_t s1_w_addr;
	data_t     s1_r;
	wb_t       s1_wb;
	// stage two onwards
	wb_t       wb_d [0:LAT-2];

	// ==========================================================
	// stage one, result select
	// ==========================================================

	always_comb begin
		case (req.op)
			OP_ADD:   res = req.a + req.b;
			OP_SUB:   res = req.a - req.b;
			// low half of the product only
			OP_MUL:   res = req.a * req.b;
			OP_AND:   res = req.a & req.b;
			OP_OR:    res = req.a | req.b;
			OP_XOR:   res = req.a ^ req.b;
			// signed compare, result is 0 or 1
			OP_CMPLT: res = ($signed(req.a) < $signed(req.b)) ? data_t'(1) : '0;
			OP_SEL:   res = req.flags[0] ? req.a : req.b;
			default:  res = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= req.valid;
		end
		s1_op     <= req.op;
		s1_w_addr <= req.w_addr;
		s1_r      <= res;
	end

	// ==========================================================
	// stage two, write-back record
	// ==========================================================

	// nop and halt write nothing, halt marks the end of a run
	always_comb begin
		s1_wb.w_en   = s1_valid && (s1_op != OP_NOP) && (s1_op != OP_HALT);
		s1_wb.halt   = s1_valid && (s1_op == OP_HALT);
		s1_wb.w_addr = s1_w_addr;
		s1_wb.r      = s1_r;
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < LAT - 1; i++) begin
				wb_d[i].w_en <= 1'b0;
				wb_d[i].halt <= 1'b0;
			end
		end else begin
			wb_d[0] <= s1_wb;
			// extra delay only when the latency exceeds two
			for (int i = 1; i < LAT - 1; i++) begin
				wb_d[i] <= wb_d[i-1];
			end
		end
	end

	assign wb = wb_d[LAT-2];

endmodule

// ==== pvp_top.sv ====
/*
 * pvp top level: sequencer, register file and alu chained into the
 * fetch, read, execute and write-back pipeline with host ports
 */
module pvp_top (
	input  logic                sys_clk,
	input  logic                rst_n,
	// program port
	input  logic                prog_we,
	input  pvp_pkg::prog_addr_t prog_addr,
	input  pvp_pkg::instr_t     prog_data,
	// register port
	input  logic                c_en,
	input  logic                c_w_en,
	input  pvp_pkg::reg_addr_t  c_addr,
	input  pvp_pkg::data_t      c_di,
	output pvp_pkg::data_t      c_do,
	// run control
	input  logic                start,
	input  pvp_pkg::data_t      r0,
	input  pvp_pkg::data_t      r1,
	output logic                busy,
	output logic                done,
	// output stream and error
	output logic                out_en,
	output pvp_pkg::data_t      out_d,
	output logic                err_stray
);
	import pvp_pkg::*;

	reg_addr_t a_addr;
	reg_addr_t b_addr;
	issue_t    issue;
	alu_req_t  alu_req;
	wb_t       wb;
	// host register access only while idle
	logic      host_en;
	// start only counts while idle
	logic      run_start;

	assign host_en   = c_en & ~busy;
	assign run_start = start & ~busy;

	// ==========================================================
	// pipeline
	// ==========================================================

	// fetch and issue
	pvp_seq i_pvp_seq (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.start     (run_start),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.wb        (wb),
		.a_addr    (a_addr),
		.b_addr    (b_addr),
		.issue     (issue),
		.busy      (busy),
		.done      (done)
	);

	// operand read and write-back
	pvp_regf i_pvp_regf (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.a_addr    (a_addr),
		.b_addr    (b_addr),
		.issue     (issue),
		.wb        (wb),
		.c_en      (host_en),
		.c_w_en    (c_w_en),
		.c_addr    (c_addr),
		.c_di      (c_di),
		.start     (run_start),
		.r0_in     (r0),
		.r1_in     (r1),
		.alu_req   (alu_req),
		.c_do      (c_do),
		.out_en    (out_en),
		.out_d     (out_d),
		.err_stray (err_stray)
	);

	// execute
	pvp_alu i_pvp_alu (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.req     (alu_req),
		.wb      (wb)
	);

endmodule

// ==== pvp_checker.sv ====
/*
 * pvp checker: watches output stream, host reads and run control
 * and compares them with the expected queues filled by the testbench
 */
module pvp_checker (
	input logic           sys_clk,
	input logic           rst_n,
	input logic           c_en,
	input logic           c_w_en,
	input pvp_pkg::data_t c_do,
	input logic           start,
	input logic           busy,
	input logic           done,
	input logic           out_en,
	input pvp_pkg::data_t out_d,
	input logic           err_stray
);
	import pvp_pkg::*;

	// expected r127 words, host read data and r0 writes per run
	data_t exp_out [$];
	data_t exp_rd [$];
	int    exp_stray [$];
	int    val_errs = 0;
	int    proto_errs = 0;
	int    stray_cnt;
	logic  rd_pend;
	logic  start_pend;
	logic  done_q;

	task automatic expect_out(input data_t v);
		exp_out.push_back(v);
	endtask

	task automatic expect_read(input data_t v);
		exp_rd.push_back(v);
	endtask

	task automatic expect_run(input int strays);
		exp_stray.push_back(strays);
	endtask

	function automatic void compare_value(input string name, input data_t exp, input data_t got);
		if (exp !== got) begin
			val_errs++;
			$display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
		end
	endfunction

	function automatic void flag_protocol(input string what);
		proto_errs++;
		$display("ERROR t=%0t %s", $time, what);
	endfunction

	// ==========================================================
	// per-cycle watch, sampled before the edge updates
	// ==========================================================

	always @(posedge sys_clk) begin
		if (!rst_n) begin
			rd_pend    = 1'b0;
			start_pend = 1'b0;
			done_q     = 1'b0;
			stray_cnt  = 0;
		end else begin
			// host read data lags its request by one cycle
			if (rd_pend) begin
				if (exp_rd.size() == 0)
					flag_protocol("host read returned data nobody expected");
				else
					compare_value("c_do", exp_rd.pop_front(), c_do);
			end
			if (start_pend && !busy)
				flag_protocol("busy did not rise the cycle after start");
			if (done_q && busy)
				flag_protocol("busy still high the cycle after done");
			if (out_en) begin
				if (exp_out.size() == 0)
					flag_protocol("out_en fired with no r127 write expected");
				else
					compare_value("out_d", exp_out.pop_front(), out_d);
			end
			if (err_stray)
				stray_cnt++;
			// end of run, every output must be in by now
			if (done) begin
				if (exp_stray.size() == 0) begin
					flag_protocol("done came without a run in progress");
				end else if (stray_cnt != exp_stray[0]) begin
					val_errs++;
					$display("FAILED t=%0t err_stray count: expected %0d, got %0d",
						$time, exp_stray[0], stray_cnt);
				end
				if (exp_stray.size() != 0)
					void'(exp_stray.pop_front());
				if (exp_out.size() != 0)
					flag_protocol("done came before all r127 writes appeared");
				stray_cnt = 0;
			end
			rd_pend    = c_en && !c_w_en && !busy;
			start_pend = start && !busy;
			done_q     = done;
		end
	end

	// leftovers mean missing responses
	task automatic final_report(output int total);
		if (exp_out.size() != 0)
			flag_protocol("some expected r127 writes never appeared");
		if (exp_rd.size() != 0)
			flag_protocol("some host reads never returned data");
		if (exp_stray.size() != 0)
			flag_protocol("some runs never signalled done");
		total = val_errs + proto_errs;
		$display("checks: %0d value errors, %0d protocol errors", val_errs, proto_errs);
	endtask

endmodule

// ==== tb_pvp.sv ====
/*
 * pvp testbench that loads programs, runs them against a sequential
 * reference model and hands the expected results to the checker
 */
module tb_pvp;
	import pvp_pkg::*;

	logic       sys_clk;
	logic       rst_n;
	logic       prog_we;
	prog_addr_t prog_addr;
	instr_t     prog_data;
	logic       c_en;
	logic       c_w_en;
	reg_addr_t  c_addr;
	data_t      c_di;
	data_t      c_do;
	logic       start;
	data_t      r0;
	data_t      r1;
	logic       busy;
	logic       done;
	logic       out_en;
	data_t      out_d;
	logic       err_stray;

	// program under test and the model's view of the registers
	instr_t  prog [$];
	data_t   shadow [0:127];
	data_t   model_out [$];
	opcode_e arith_ops [0:6] = '{OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_CMPLT};
	logic    timed_out;
	int      errs;

	always #5 sys_clk = ~sys_clk;

	pvp_top i_pvp_top (
		.sys_clk (sys_clk), .rst_n (rst_n),
		.prog_we (prog_we), .prog_addr (prog_addr), .prog_data (prog_data),
		.c_en (c_en), .c_w_en (c_w_en), .c_addr (c_addr), .c_di (c_di), .c_do (c_do),
		.start (start), .r0 (r0), .r1 (r1), .busy (busy), .done (done),
		.out_en (out_en), .out_d (out_d), .err_stray (err_stray)
	);

	pvp_checker i_pvp_checker (
		.sys_clk (sys_clk), .rst_n (rst_n), .c_en (c_en), .c_w_en (c_w_en),
		.c_do (c_do), .start (start), .busy (busy), .done (done),
		.out_en (out_en), .out_d (out_d), .err_stray (err_stray)
	);

	// ==========================================================
	// reference model
	// ==========================================================

	// runs prog in order up to the halt and returns the count of r0 writes
	function automatic int pvp_model(input data_t r0v, input data_t r1v);
		data_t  a;
		data_t  b;
		data_t  r;
		instr_t ins;
		int     pc;
		int     strays;
		strays    = 0;
		pc        = 0;
		shadow[0] = r0v;
		shadow[1] = r1v;
		model_out.delete();
		while (pc < prog.size() && prog[pc].op != OP_HALT) begin
			ins = prog[pc];
			a   = shadow[ins.a_addr];
			b   = shadow[ins.b_addr];
			case (ins.op)
				OP_ADD:   r = a + b;
				OP_SUB:   r = a - b;
				OP_MUL:   r = a * b;
				OP_AND:   r = a & b;
				OP_OR:    r = a | b;
				OP_XOR:   r = a ^ b;
				OP_CMPLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				// flag bit 0 picks a
				OP_SEL:   r = shadow[2][0] ? a : b;
				default:  r = '0;
			endcase
			if (ins.op != OP_NOP) begin
				case (ins.w_addr)
					7'd0:    strays++;
					// r1 reads come from the start value
					7'd1:    ;
					7'd2:    shadow[2] = data_t'(r[1:0]);
					default: shadow[ins.w_addr] = r;
				endcase
				if (ins.w_addr == 7'd127)
					model_out.push_back(r);
			end
			pc++;
		end
		return strays;
	endfunction

	// instruction plus the three nops a dependent reader needs
	function automatic void add_spaced(input opcode_e op, input int a, input int b, input int w);
		instr_t ins;
		ins.op     = op;
		ins.a_addr = reg_addr_t'(a);
		ins.b_addr = reg_addr_t'(b);
		ins.w_addr = reg_addr_t'(w);
		prog.push_back(ins);
		if (op != OP_HALT) begin
			ins = '0;
			repeat (3) prog.push_back(ins);
		end
	endfunction

	// ==========================================================
	// host port and run driving
	// ==========================================================

	task automatic host_access(input logic we, input int a, input data_t d);
		@(posedge sys_clk);
		c_en   <= 1'b1;
		c_w_en <= we;
		c_addr <= reg_addr_t'(a);
		c_di   <= d;
	endtask

	task automatic host_idle();
		@(posedge sys_clk);
		c_en   <= 1'b0;
		c_w_en <= 1'b0;
	endtask

	// load prog, start it, optionally poke start mid-run, wait for done
	task automatic run_prog(input data_t r0v, input data_t r1v, input logic poke);
		int strays;
		int cycles;
		foreach (prog[i]) begin
			@(posedge sys_clk);
			prog_we   <= 1'b1;
			prog_addr <= prog_addr_t'(i);
			prog_data <= prog[i];
		end
		strays = pvp_model(r0v, r1v);
		foreach (model_out[i])
			i_pvp_checker.expect_out(model_out[i]);
		i_pvp_checker.expect_run(strays);
		@(posedge sys_clk);
		prog_we <= 1'b0;
		start   <= 1'b1;
		r0      <= r0v;
		r1      <= r1v;
		@(posedge sys_clk);
		start <= 1'b0;
		if (poke) begin
			repeat (4) @(posedge sys_clk);
			// must be ignored since the run is still busy
			start <= 1'b1;
			r0    <= ~r0v;
			@(posedge sys_clk);
			start <= 1'b0;
		end
		cycles = 0;
		do begin
			@(posedge sys_clk);
			cycles++;
		end while (!done && cycles < 1000);
		if (!done) begin
			timed_out = 1'b1;
			$display("timeout at t=%0t: done never came within 1000 cycles", $time);
		end
	endtask

	// ==========================================================
	// stimulus
	// ==========================================================

	initial begin
		data_t v;
		void'($urandom(54197));
		sys_clk   = 1'b0;
		rst_n     = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		c_en      = 1'b0;
		c_w_en    = 1'b0;
		c_addr    = '0;
		c_di      = '0;
		start     = 1'b0;
		r0        = '0;
		r1        = '0;
		timed_out = 1'b0;
		shadow    = '{default: '0};
		repeat (4) @(posedge sys_clk);
		rst_n <= 1'b1;

		// register port writes to 3..126 and reads them back
		for (int i = 3; i < 127; i++) begin
			v         = $urandom();
			shadow[i] = v;
			host_access(1'b1, i, v);
		end
		for (int i = 3; i < 127; i++) begin
			i_pvp_checker.expect_read(shadow[i]);
			host_access(1'b0, i, '0);
		end
		host_idle();

		// random arithmetic whose last writes go to r127
		for (int n = 0; n < 3; n++) begin
			prog.delete();
			for (int k = 0; k < 16; k++) begin
				add_spaced(arith_ops[$urandom_range(6)], $urandom_range(126),
					$urandom_range(126), (k < 12) ? 3 + $urandom_range(124) : 127);
			end
			add_spaced(OP_HALT, 0, 0, 0);
			run_prog($urandom(), $urandom(), 1'b0);
			i_pvp_checker.expect_read(shadow[0]);
			host_access(1'b0, 0, '0);
			i_pvp_checker.expect_read(shadow[1]);
			host_access(1'b0, 1, '0);
			// every intermediate result must sit in its register
			for (int i = 3; i < 127; i++) begin
				i_pvp_checker.expect_read(shadow[i]);
				host_access(1'b0, i, '0);
			end
			host_idle();
		end

		// r2 takes the low bits of r0 and then steers the select
		for (int n = 0; n < 2; n++) begin
			v      = $urandom();
			// each flag bit is set in one of the two passes
			v[1:0] = (n == 0) ? 2'b01 : 2'b10;
			prog.delete();
			add_spaced(OP_OR, 0, 0, 2);
			add_spaced(OP_SEL, 3 + n, 10, 20);
			add_spaced(OP_OR, 20, 20, 127);
			add_spaced(OP_HALT, 0, 0, 0);
			run_prog(v, $urandom(), 1'b0);
			i_pvp_checker.expect_read(shadow[2]);
			host_access(1'b0, 2, '0);
			host_idle();
		end

		// stray r0 writes where the second pass also pokes start while busy
		for (int n = 0; n < 2; n++) begin
			prog.delete();
			add_spaced(OP_ADD, 3, 4, 0);
			add_spaced(OP_XOR, 5, 6, 0);
			add_spaced(OP_OR, 0, 1, 127);
			add_spaced(OP_HALT, 0, 0, 0);
			run_prog($urandom(), $urandom(), n == 1);
			i_pvp_checker.expect_read(shadow[0]);
			host_access(1'b0, 0, '0);
			host_idle();
		end

		repeat (2) @(posedge sys_clk);
		i_pvp_checker.final_report(errs);
		if (errs == 0 && !timed_out) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
pvp_pkg.sv
pvp_seq.sv
pvp_regf.sv
pvp_alu.sv
pvp_top.sv
pvp_checker.sv
tb_pvp.sv

// ==== Makefile ====
# pvp testbench built and run with verilator

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module tb_pvp -Mdir obj_dir
	./obj_dir/Vtb_pvp > sim.log 2>&1; cat sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
